/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := lsu_tb
FILELIST  := list.f
RUN_ARGS  := +verilator+error+limit+1000

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard include/*.svh verilog/*.sv verif/*.sv) $(FILELIST)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* include/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ***************************************************************************
// load/store path sizing
// ***************************************************************************

// data and address width of the integer pipeline
`define LSU_XLEN 32

// tightly coupled data RAM, counted in 32-bit words
`define LSU_RAM_WORDS 256

// word address width, log2 of LSU_RAM_WORDS
`define LSU_RAM_AW 8

`endif

/* list.f */
+incdir+include
verilog/lsu_pkg.sv
verilog/stage_link.sv
verilog/wb_bus.sv
verilog/address_stage.sv
verilog/memory_stage.sv
verilog/dtim.sv
verilog/lsu_top.sv
verif/lsu_props.sv
verif/lsu_tb.sv

/* verif/lsu_props.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_props (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  logic [`LSU_RAM_AW-1:0]  adr,
  input  logic [3:0]              sel,
  input  logic [`LSU_XLEN-1:0]    dat_w,
  input  logic                    ack,
  input  logic                    res_valid,
  input  logic                    link_valid,
  input  logic                    link_ready,
  input  lsu_pkg::mem_req_t       link_payload
);

  int failures = 0;

  // ***************************************************************************
  // Wishbone classic rules between the memory stage and the RAM
  // ***************************************************************************

  // the strobe and its cycle stay up until the slave acks
  stb_in_cycle: assert property (@(posedge clock) disable iff (reset == 0)
    stb && !ack |=> stb && cyc)
    else begin
      $error("strobe or cycle dropped before ack");
      failures++;
    end

  cycle_release: assert property (@(posedge clock) disable iff (reset == 0)
    ack |=> !cyc && !stb)                        // master ends its cycle right after ack
    else begin
      $error("bus cycle still open after ack");
      failures++;
    end

  // a strobe still waiting for ack keeps its request fields
  request_stable: assert property (@(posedge clock) disable iff (reset == 0)
    stb && !ack |=> $stable(adr) && $stable(we) && $stable(sel) && $stable(dat_w))
    else begin
      $error("request changed before ack");
      failures++;
    end

  ack_with_stb: assert property (@(posedge clock) disable iff (reset == 0) ack |-> stb)
    else begin
      $error("ack without stb");
      failures++;
    end

  ack_single: assert property (@(posedge clock) disable iff (reset == 0) ack |=> !ack)
    else begin
      $error("ack held for two cycles");
      failures++;
    end

  // ack rises on one edge and the result is registered on the next one
  result_after_ack: assert property (@(posedge clock) disable iff (reset == 0)
    ack |=> res_valid)
    else begin
      $error("no result after ack");
      failures++;
    end

  fault_skips_bus: assert property (@(posedge clock) disable iff (reset == 0)
    link_valid && link_ready && link_payload.exception |=> !stb)
    else begin
      $error("faulting item started a bus cycle");
      failures++;
    end

endmodule

bind memory_stage lsu_props u_props (
  .clock        (clock),
  .reset        (reset),
  .cyc          (bus.cyc),
  .stb          (bus.stb),
  .we           (bus.we),
  .adr          (bus.adr),
  .sel          (bus.sel),
  .dat_w        (bus.dat_w),
  .ack          (bus.ack),
  .res_valid    (res_valid),
  .link_valid   (in.valid),
  .link_ready   (in.ready),
  .link_payload (in.payload)
);

/* verif/lsu_tb.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_tb;

  localparam int fill_words = `LSU_RAM_WORDS;
  localparam int pair_count = 16;
  localparam int lane_words = 8;                 // 8 requests per word
  localparam int extend_words = 8;               // 12 loads per word
  localparam int fault_words = 2;                // 13 requests per word
  localparam int stream_count = 64;
  localparam int num_requests = fill_words + 2 * pair_count + 8 * lane_words +
                                12 * extend_words + 13 * fault_words + stream_count;
  localparam int cycle_limit = 20 * num_requests + 100;

  typedef struct packed {
    logic [4:0]            rd;
    logic [`LSU_XLEN-1:0]  data;
    logic                  write;
    logic                  exception;
    lsu_pkg::cause_t       cause;
    logic [`LSU_XLEN-1:0]  tval;
  } result_t;

  logic clock, reset, req_valid, req_ready, res_valid, res_write, res_exception, started;
  lsu_pkg::mem_op_t req_op;
  lsu_pkg::cause_t res_cause;
  logic [`LSU_XLEN-1:0] req_base, req_offset, req_wdata, res_data, res_tval;
  logic [4:0] req_rd, res_rd;
  logic [7:0] ref_mem [4*`LSU_RAM_WORDS];        // byte image of the RAM
  result_t exp_q [$];
  integer seed = 32'h7cdd_28c9;
  int errors = 0;
  int flow_errors = 0;
  int cycles = 0;
  int stalls = 0;

  lsu_top u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [9:0] rand_word();
    logic [31:0] rnd;
    rnd = $random(seed);
    return {rnd[9:2], 2'b00};
  endfunction

  function automatic logic faults(input lsu_pkg::mem_op_t op, input logic [9:0] a);
    case (op)
      lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: faults = a[0];
      lsu_pkg::op_lw, lsu_pkg::op_sw: faults = (a[1:0] != 2'b00);
      default: faults = 1'b0;
    endcase
  endfunction

  // little endian read from the reference image, extended by op
  function automatic logic [31:0] read_ref(input lsu_pkg::mem_op_t op, input logic [9:0] a);
    logic [31:0] raw;
    raw = {ref_mem[a + 10'd3], ref_mem[a + 10'd2], ref_mem[a + 10'd1], ref_mem[a]};
    case (op)
      lsu_pkg::op_lb:  read_ref = {{24{raw[7]}}, raw[7:0]};
      lsu_pkg::op_lh:  read_ref = {{16{raw[15]}}, raw[15:0]};
      lsu_pkg::op_lbu: read_ref = {24'b0, raw[7:0]};
      lsu_pkg::op_lhu: read_ref = {16'b0, raw[15:0]};
      default:         read_ref = raw;
    endcase
  endfunction

  // drives one request and predicts its result once it is accepted
  task automatic issue(input lsu_pkg::mem_op_t op, input logic [9:0] a,
                       input logic [31:0] wdata, input logic [4:0] rd);
    logic [31:0] offset;
    result_t r;
    offset = $random(seed);
    started = 1'b1;
    req_valid = 1'b1;
    req_op = op;
    req_offset = {{20{offset[11]}}, offset[11:0]};
    req_base = {22'b0, a} - req_offset;
    req_wdata = wdata;
    req_rd = rd;
    while (!req_ready) begin
      stalls++;                                  // request held while the DUT is busy
      @(negedge clock);
    end
    r = '0;
    r.rd = rd;
    if (faults(op, a)) begin
      r.exception = 1'b1;
      r.cause = lsu_pkg::is_store(op) ? lsu_pkg::cause_store_misaligned
                                      : lsu_pkg::cause_load_misaligned;
      r.tval = {22'b0, a};
    end else if (lsu_pkg::is_load(op)) begin
      r.write = 1'b1;
      r.data = read_ref(op, a);
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (i == 0 || (i == 1 && op != lsu_pkg::op_sb) || op == lsu_pkg::op_sw) begin
          ref_mem[a + 10'(i)] = wdata[8*i +: 8];
        end
      end
    end
    exp_q.push_back(r);
    @(negedge clock);
  endtask

  task automatic go_idle();
    req_valid = 1'b0;
    req_op = lsu_pkg::op_none;
    @(negedge clock);
  endtask

  task automatic mismatch(input string field, input logic [31:0] got, input logic [31:0] want);
    errors++;
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, field, got, want);
  endtask

  task automatic check_result();
    result_t want;
    if (exp_q.size() == 0) begin
      errors++;
      $display("result at %0t arrived with no request outstanding", $time);
    end else begin
      want = exp_q.pop_front();
      assert (res_rd == want.rd) else mismatch("res_rd", 32'(res_rd), 32'(want.rd));
      assert (res_write == want.write)
        else mismatch("res_write", 32'(res_write), 32'(want.write));
      assert (res_exception == want.exception)
        else mismatch("res_exception", 32'(res_exception), 32'(want.exception));
      if (want.exception) begin
        assert (res_cause == want.cause)
          else mismatch("res_cause", 32'(res_cause), 32'(want.cause));
        assert (res_tval == want.tval) else mismatch("res_tval", res_tval, want.tval);
      end
      if (want.write || want.exception) begin
        assert (res_data == want.data) else mismatch("res_data", res_data, want.data);
      end
    end
  endtask

  task automatic close_run(input logic timed_out);
    int failures;
    failures = u_dut.u_memory_stage.u_props.failures;
    $display("errors: %0d result, %0d flow, %0d assertion", errors, flow_errors, failures);
    if (errors == 0 && flow_errors == 0 && failures == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // outputs settle after the rising edge, so they are read on the falling one
  always @(negedge clock) begin
    if (reset) begin
      if (!started) begin
        assert (!res_valid) else mismatch("res_valid before first request", 32'(res_valid), 0);
        assert (req_ready) else mismatch("req_ready after reset", 32'(req_ready), 1);
      end
      if (res_valid) check_result();
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      close_run(1'b1);
    end
  end

  initial begin
    logic [9:0] a;
    int stall_mark;
    {req_valid, req_base, req_offset, req_wdata, req_rd, started} = '0;
    req_op = lsu_pkg::op_none;
    reset = 1'b0;
    repeat (4) @(negedge clock);
    reset = 1'b1;
    repeat (4) @(negedge clock);                 // idle window after reset
    for (int w = 0; w < fill_words; w++) begin
      issue(lsu_pkg::op_sw, 10'(w * 4), (32'(w) + 32'd1) * 32'h9e37_79b1, 5'(w));
    end
    for (int k = 0; k < pair_count; k++) begin
      a = rand_word();
      issue(lsu_pkg::op_sw, a, $random(seed), 5'd1);
      issue(lsu_pkg::op_lw, a, 32'd0, 5'(k + 2));
    end
    go_idle();
    for (int k = 0; k < lane_words; k++) begin
      a = rand_word();
      for (int off = 0; off < 4; off++) issue(lsu_pkg::op_sb, a + 10'(off), $random(seed), 5'd2);
      issue(lsu_pkg::op_lw, a, 32'd0, 5'd3);
      issue(lsu_pkg::op_sh, a, $random(seed), 5'd4);
      issue(lsu_pkg::op_sh, a + 10'd2, $random(seed), 5'd4);
      issue(lsu_pkg::op_lw, a, 32'd0, 5'd5);
    end
    for (int k = 0; k < extend_words; k++) begin
      a = rand_word();
      for (int off = 0; off < 4; off++) begin
        issue(lsu_pkg::op_lb, a + 10'(off), 32'd0, 5'd6);
        issue(lsu_pkg::op_lbu, a + 10'(off), 32'd0, 5'd7);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue(lsu_pkg::op_lh, a + 10'(off), 32'd0, 5'd8);
        issue(lsu_pkg::op_lhu, a + 10'(off), 32'd0, 5'd9);
      end
    end
    go_idle();
    for (int k = 0; k < fault_words; k++) begin
      a = rand_word();
      for (int off = 1; off < 4; off += 2) begin
        issue(lsu_pkg::op_lh, a + 10'(off), 32'd0, 5'd10);
        issue(lsu_pkg::op_lhu, a + 10'(off), 32'd0, 5'd11);
        issue(lsu_pkg::op_sh, a + 10'(off), $random(seed), 5'd12);
      end
      for (int off = 1; off < 4; off++) begin
        issue(lsu_pkg::op_lw, a + 10'(off), 32'd0, 5'd13);
        issue(lsu_pkg::op_sw, a + 10'(off), $random(seed), 5'd14);
      end
      issue(lsu_pkg::op_lw, a, 32'd0, 5'd15);     // faulting stores left the word alone
    end
    stall_mark = stalls;
    for (int k = 0; k < stream_count; k++) begin
      a = 10'($random(seed));
      issue(lsu_pkg::mem_op_t'(4'd1 + {1'b0, a[6:4]}), rand_word() | {8'b0, a[1:0]},
            $random(seed), 5'(k));
    end
    go_idle();
    while (exp_q.size() != 0) @(negedge clock);
    repeat (4) @(negedge clock);
    assert (stalls > stall_mark) else begin
      flow_errors++;
      $display("req_ready never dropped while requests were held back to back");
    end
    close_run(1'b0);
  end

endmodule

/* verilog/address_stage.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module address_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  input  lsu_pkg::mem_op_t      req_op,
  input  logic [`LSU_XLEN-1:0]  req_base,
  input  logic [`LSU_XLEN-1:0]  req_offset,
  input  logic [`LSU_XLEN-1:0]  req_wdata,
  input  logic [4:0]            req_rd,
  output logic                  req_ready,
  stage_link.source             out
);

  logic                  r_valid;
  lsu_pkg::mem_req_t     r_item;
  lsu_pkg::mem_req_t     next_item;
  logic [`LSU_XLEN-1:0]  addr;
  logic [3:0]            lanes;
  logic [`LSU_XLEN-1:0]  wdata;
  logic                  misaligned;

  assign addr = req_base + req_offset;

  // ***************************************************************************
  // byte lanes, store data replication and alignment check
  // ***************************************************************************

  always_comb begin
    lanes = 4'b0000;
    wdata = req_wdata;
    misaligned = 1'b0;
    case (req_op)
      lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: begin
        lanes = 4'b0001 << addr[1:0];
        wdata = {4{req_wdata[7:0]}};
      end
      lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: begin
        lanes = 4'b0011 << {addr[1], 1'b0};
        wdata = {2{req_wdata[15:0]}};
        misaligned = addr[0];                    // halfword must sit on an even byte
      end
      lsu_pkg::op_lw, lsu_pkg::op_sw: begin
        lanes = 4'b1111;
        misaligned = (addr[1:0] != 2'b00);
      end
      default: begin
        lanes = 4'b0000;                         // no memory access at all
      end
    endcase
  end

  always_comb begin
    next_item.op = req_op;
    next_item.word_addr = addr[`LSU_RAM_AW+1:2];
    next_item.offset = addr[1:0];
    next_item.lanes = misaligned ? 4'b0000 : lanes;
    next_item.wdata = wdata;
    next_item.rd = req_rd;
    next_item.exception = misaligned;
    next_item.addr = addr;
    if (!misaligned) begin
      next_item.cause = lsu_pkg::cause_none;
    end else if (lsu_pkg::is_store(req_op)) begin
      next_item.cause = lsu_pkg::cause_store_misaligned;
    end else begin
      next_item.cause = lsu_pkg::cause_load_misaligned;
    end
  end

  // the slot frees up on the same edge that the memory stage takes the item
  assign req_ready = !r_valid || out.ready;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r_valid <= 1'b0;
    end else if (req_valid && req_ready) begin
      r_valid <= 1'b1;
    end else if (out.ready) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      r_item <= next_item;
    end
  end

  assign out.valid = r_valid;
  assign out.payload = r_item;

endmodule

/* verilog/dtim.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module dtim (
  input  logic  clock,
  input  logic  reset,
  wb_bus.slave  bus
);

  logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
  logic                 access;

  // a new access is a strobe that has not been acknowledged yet
  assign access = bus.cyc && bus.stb && !bus.ack;

  // ***************************************************************************
  // storage with per-byte write enables, read data lines up with ack
  // ***************************************************************************

  always_ff @(posedge clock) begin
    if (access) begin
      bus.dat_r <= mem[bus.adr];                 // old word comes back on a store
      if (bus.we) begin
        for (int i = 0; i < 4; i++) begin
          if (bus.sel[i]) begin
            mem[bus.adr][8*i +: 8] <= bus.dat_w[8*i +: 8];
          end
        end
      end
    end
  end

  // single-cycle ack, the !ack term keeps it from repeating
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= access;
    end
  end

endmodule

/* verilog/lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

  // ***************************************************************************
  // operation and exception encodings
  // ***************************************************************************

  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_lbu  = 4'd4,
    op_lhu  = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } mem_op_t;

  // codes follow the RISC-V mcause numbering
  typedef enum logic [3:0] {
    cause_none             = 4'd0,
    cause_load_misaligned  = 4'd4,
    cause_store_misaligned = 4'd6
  } cause_t;

  // ***************************************************************************
  // payload handed from the address stage to the memory stage
  // ***************************************************************************

  typedef struct packed {
    mem_op_t                  op;
    logic [`LSU_RAM_AW-1:0]   word_addr;
    logic [1:0]               offset;     // byte offset inside the word
    logic [3:0]               lanes;
    logic [`LSU_XLEN-1:0]     wdata;      // already replicated into its lanes
    logic [4:0]               rd;
    logic                     exception;
    cause_t                   cause;
    logic [`LSU_XLEN-1:0]     addr;       // full address, reported as tval
  } mem_req_t;

  function automatic logic is_load(mem_op_t op);
    return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
  endfunction

  function automatic logic is_store(mem_op_t op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

endpackage

/* verilog/lsu_top.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  input  lsu_pkg::mem_op_t      req_op,
  input  logic [`LSU_XLEN-1:0]  req_base,
  input  logic [`LSU_XLEN-1:0]  req_offset,
  input  logic [`LSU_XLEN-1:0]  req_wdata,
  input  logic [4:0]            req_rd,
  output logic                  req_ready,
  output logic                  res_valid,
  output logic [4:0]            res_rd,
  output logic [`LSU_XLEN-1:0]  res_data,
  output logic                  res_write,
  output logic                  res_exception,
  output lsu_pkg::cause_t       res_cause,
  output logic [`LSU_XLEN-1:0]  res_tval
);

  stage_link link ();
  wb_bus     bus ();

  address_stage u_address_stage (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_base   (req_base),
    .req_offset (req_offset),
    .req_wdata  (req_wdata),
    .req_rd     (req_rd),
    .req_ready  (req_ready),
    .out        (link.source)
  );

  memory_stage u_memory_stage (
    .clock         (clock),
    .reset         (reset),
    .in            (link.sink),
    .bus           (bus.master),
    .res_valid     (res_valid),
    .res_rd        (res_rd),
    .res_data      (res_data),
    .res_write     (res_write),
    .res_exception (res_exception),
    .res_cause     (res_cause),
    .res_tval      (res_tval)
  );

  dtim u_dtim (
    .clock (clock),
    .reset (reset),
    .bus   (bus.slave)
  );

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module memory_stage (
  input  logic                  clock,
  input  logic                  reset,
  stage_link.sink               in,
  wb_bus.master                 bus,
  output logic                  res_valid,
  output logic [4:0]            res_rd,
  output logic [`LSU_XLEN-1:0]  res_data,
  output logic                  res_write,
  output logic                  res_exception,
  output lsu_pkg::cause_t       res_cause,
  output logic [`LSU_XLEN-1:0]  res_tval
);

  typedef enum logic [1:0] {
    st_idle,
    st_bus,
    st_done
  } state_t;

  state_t                state;
  lsu_pkg::mem_req_t     item;
  logic                  bus_needed;
  logic                  finish;
  logic [`LSU_XLEN-1:0]  shifted;
  logic [`LSU_XLEN-1:0]  load_value;

  // exceptions and non-memory ops go straight to the result without a bus cycle
  assign bus_needed = !in.payload.exception &&
                      (lsu_pkg::is_load(in.payload.op) || lsu_pkg::is_store(in.payload.op));

  assign in.ready = (state == st_idle);
  assign finish = ((state == st_bus) && bus.ack) || (state == st_done);

  // ***************************************************************************
  // Wishbone master, everything comes from the captured item
  // ***************************************************************************

  assign bus.cyc = (state == st_bus);
  assign bus.stb = (state == st_bus);
  assign bus.we = lsu_pkg::is_store(item.op);
  assign bus.adr = item.word_addr;
  assign bus.sel = lsu_pkg::is_store(item.op) ? item.lanes : 4'b0000;
  assign bus.dat_w = item.wdata;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      state <= st_idle;
      res_valid <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (in.valid) begin
            state <= bus_needed ? st_bus : st_done;
          end
        end
        st_bus: begin
          if (bus.ack) begin
            state <= st_idle;                    // cyc and stb fall right after ack
            res_valid <= 1'b1;
          end
        end
        st_done: begin
          state <= st_idle;
          res_valid <= 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ***************************************************************************
  // load alignment and extension
  // ***************************************************************************

  assign shifted = bus.dat_r >> {item.offset, 3'b000};

  always_comb begin
    case (item.op)
      lsu_pkg::op_lb:  load_value = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::op_lh:  load_value = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::op_lbu: load_value = {24'b0, shifted[7:0]};
      lsu_pkg::op_lhu: load_value = {16'b0, shifted[15:0]};
      lsu_pkg::op_lw:  load_value = bus.dat_r;
      default:         load_value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if ((state == st_idle) && in.valid) begin
      item <= in.payload;
    end
    if (finish) begin
      res_rd <= item.rd;
      res_exception <= item.exception;
      res_cause <= item.cause;
      res_tval <= item.exception ? item.addr : '0;
      // only a completed load writes the register file
      res_write <= lsu_pkg::is_load(item.op) && !item.exception;
      res_data <= (lsu_pkg::is_load(item.op) && !item.exception) ? load_value : '0;
    end
  end

endmodule

/* verilog/stage_link.sv */
`timescale 1ns/100ps

// one pipeline slot between two stages, moves when valid and ready meet on an edge
interface stage_link;

  logic               valid;
  logic               ready;
  lsu_pkg::mem_req_t  payload;

  // producing stage keeps valid and payload steady until the transfer edge
  modport source (
    output valid,
    output payload,
    input  ready
  );

  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

/* verilog/wb_bus.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

// Wishbone classic, word addressed, four byte lanes
interface wb_bus;

  logic                    cyc;
  logic                    stb;
  logic                    we;
  logic [`LSU_RAM_AW-1:0]  adr;
  logic [3:0]              sel;
  logic [`LSU_XLEN-1:0]    dat_w;
  logic [`LSU_XLEN-1:0]    dat_r;
  logic                    ack;

  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output sel,
    output dat_w,
    input  dat_r,
    input  ack
  );

  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  sel,
    input  dat_w,
    output dat_r,
    output ack
  );

endinterface
